// ==== audio_macros.svh ====
// audio path constants
`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// width of one signed sample
`define AUDIO_SAMPLE_W 24

// bit-clock periods per channel slot
`define AUDIO_SLOT_W 32

// sys_clk cycles per bit-clock half period
// 2 slots * 32 bits * 2 halves * 2 cycles = 256 cycles per frame
`define AUDIO_BCLK_HALF 2

// stereo frames held by the buffer
`define AUDIO_FIFO_DEPTH 4

// stable cycles before a switch change counts
`define AUDIO_DEBOUNCE_CYCLES 64

`endif

// ==== audio_pkg.sv ====
// audio sample path types
`default_nettype none

`include "audio_macros.svh"

package audio_pkg;

  // ************************************************************
  // sample and slot position
  // ************************************************************

  // one two's complement sample
  typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

  // bit position inside a 32-bit slot
  typedef logic [4:0] slot_cnt_t;

endpackage

`default_nettype wire

// ==== ctrl_pkg.sv ====
// control side types
`default_nettype none

package ctrl_pkg;

  localparam int MODE_W = 2;

  // ************************************************************
  // channel mode
  // ************************************************************

  // encoding matches the board switch bits one to one
  typedef enum logic [MODE_W-1:0] {
    MODE_PASS = 2'b00,
    MODE_SWAP = 2'b01,
    MODE_MONO = 2'b10,
    MODE_MUTE = 2'b11
  } chan_mode_e;

  // switch pair to mode
  function automatic chan_mode_e decode_switches(input logic [MODE_W-1:0] sw);
    return chan_mode_e'(sw);
  endfunction

endpackage

`default_nettype wire

// ==== i2s_clk_gen.sv ====
// i2s bit and word clock generator
`timescale 1ns/100ps
`default_nettype none

`include "audio_macros.svh"

module i2s_clk_gen
  import audio_pkg::*;
(
  input  logic      sys_clk,
  input  logic      rst_n_i,
  output logic      bclk_o,
  output logic      lrclk_o,
  output logic      bit_sample_stb_o,
  output logic      bit_shift_stb_o,
  output slot_cnt_t slot_pos_o
);

localparam int HALF  = `AUDIO_BCLK_HALF;
localparam int DIV_W = $clog2(HALF + 1);

logic [DIV_W-1:0] div_cnt;
logic             div_wrap;

// last cycle of a bit-clock half period
assign div_wrap = (div_cnt == DIV_W'(HALF - 1));

always_ff @( posedge sys_clk or negedge rst_n_i )
  if( !rst_n_i )
    begin
      div_cnt          <= '0;
      bclk_o           <= 1'b0;
      lrclk_o          <= 1'b0;
      bit_sample_stb_o <= 1'b0;
      bit_shift_stb_o  <= 1'b0;
      slot_pos_o       <= '0;
    end
  else
    begin
      div_cnt          <= div_wrap ? '0 : div_cnt + 1'b1;
      // strobes line up with the new bclk level
      bit_sample_stb_o <= div_wrap && !bclk_o;
      bit_shift_stb_o  <= div_wrap && bclk_o;
      if( div_wrap )
        bclk_o <= !bclk_o;
      // falling edge, next bit position
      if( div_wrap && bclk_o )
        begin
          if( slot_pos_o == slot_cnt_t'(`AUDIO_SLOT_W - 1) )
            begin
              slot_pos_o <= '0;
              lrclk_o    <= !lrclk_o;
            end
          else
            slot_pos_o <= slot_pos_o + 1'b1;
        end
    end

// sample and shift strobes never together
a_strobe_exclusive: assert property (
  @( posedge sys_clk ) disable iff ( !rst_n_i )
  !(bit_sample_stb_o && bit_shift_stb_o)
);

endmodule

`default_nettype wire

// ==== i2s_rx.sv ====
// i2s receiver toward the adc
`timescale 1ns/100ps
`default_nettype none

`include "audio_macros.svh"

module i2s_rx
  import audio_pkg::*;
(
  input  logic      sys_clk,
  input  logic      rst_n_i,
  input  logic      adc_data_i,
  input  logic      lrclk_i,
  input  logic      bit_sample_stb_i,
  input  slot_cnt_t slot_pos_i,
  output logic      frame_valid_o,
  input  logic      frame_ready_i,
  output sample_t   left_o,
  output sample_t   right_o,
  output logic      overrun_o
);

localparam int W = `AUDIO_SAMPLE_W;

// msb-first shift of the first W-1 bits
logic [W-2:0] shreg;
logic         data_pos;
logic         last_bit;

// positions 1 to W carry sample bits
assign data_pos = (slot_pos_i != '0) && (slot_pos_i <= slot_cnt_t'(W));
assign last_bit = bit_sample_stb_i && (slot_pos_i == slot_cnt_t'(W));

// ************************************************************
// deserializer
// ************************************************************

always_ff @( posedge sys_clk )
  begin
    if( bit_sample_stb_i && data_pos )
      shreg <= {shreg[W-3:0], adc_data_i};
    // lsb arrives straight from the pin
    if( last_bit )
      begin
        if( lrclk_i )
          right_o <= {shreg, adc_data_i};
        else
          left_o  <= {shreg, adc_data_i};
      end
  end

// ************************************************************
// frame handoff
// ************************************************************

always_ff @( posedge sys_clk or negedge rst_n_i )
  if( !rst_n_i )
    begin
      frame_valid_o <= 1'b0;
      overrun_o     <= 1'b0;
    end
  else
    begin
      // one-cycle offer once the right sample is in
      frame_valid_o <= last_bit && lrclk_i;
      // no retry, a refused frame is lost
      if( frame_valid_o && !frame_ready_i )
        overrun_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== frame_fifo.sv ====
// stereo frame fifo
`timescale 1ns/100ps
`default_nettype none

`include "audio_macros.svh"

module frame_fifo
  import audio_pkg::*;
(
  input  logic    sys_clk,
  input  logic    rst_n_i,
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  sample_t in_left_i,
  input  sample_t in_right_i,
  output logic    out_valid_o,
  input  logic    out_ready_i,
  output sample_t out_left_o,
  output sample_t out_right_o
);

localparam int DEPTH = `AUDIO_FIFO_DEPTH;
localparam int PTR_W = $clog2(DEPTH);
localparam int CNT_W = $clog2(DEPTH + 1);

sample_t          left_mem  [DEPTH];
sample_t          right_mem [DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic             push;
logic             pop;

assign in_ready_o  = (count != CNT_W'(DEPTH));
assign out_valid_o = (count != '0);
assign push        = in_valid_i && in_ready_o;
assign pop         = out_valid_o && out_ready_i;

// show-ahead read
assign out_left_o  = left_mem[rd_ptr];
assign out_right_o = right_mem[rd_ptr];

// storage
always_ff @( posedge sys_clk )
  if( push )
    begin
      left_mem[wr_ptr]  <= in_left_i;
      right_mem[wr_ptr] <= in_right_i;
    end

// pointers and occupancy
always_ff @( posedge sys_clk or negedge rst_n_i )
  if( !rst_n_i )
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
  else
    begin
      if( push )
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if( pop )
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // simultaneous push and pop keeps the count
      case( {push, pop} )
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end

// accepted write never hits a full fifo
a_no_write_full: assert property (
  @( posedge sys_clk ) disable iff ( !rst_n_i )
  push |-> (count < CNT_W'(DEPTH))
);

// accepted read never hits an empty fifo
a_no_read_empty: assert property (
  @( posedge sys_clk ) disable iff ( !rst_n_i )
  pop |-> (count != '0)
);

endmodule

`default_nettype wire

// ==== switch_debouncer.sv ====
// channel mode switch debouncer
`timescale 1ns/100ps
`default_nettype none

`include "audio_macros.svh"

module switch_debouncer
  import ctrl_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n_i,
  input  logic [1:0] sw_i,
  output chan_mode_e mode_o
);

localparam int DEB   = `AUDIO_DEBOUNCE_CYCLES;
localparam int CNT_W = $clog2(DEB + 1);

logic [1:0]       sw_meta;
logic [1:0]       sw_sync;
logic [1:0]       sw_last;
logic [CNT_W-1:0] stable_cnt;

always_ff @( posedge sys_clk or negedge rst_n_i )
  if( !rst_n_i )
    begin
      sw_meta    <= '0;
      sw_sync    <= '0;
      sw_last    <= '0;
      stable_cnt <= '0;
      mode_o     <= MODE_PASS;
    end
  else
    begin
      // two-stage synchronizer
      sw_meta <= sw_i;
      sw_sync <= sw_meta;
      sw_last <= sw_sync;
      // any change restarts the stability window
      if( sw_sync != sw_last )
        stable_cnt <= '0;
      else if( stable_cnt != CNT_W'(DEB) )
        stable_cnt <= stable_cnt + 1'b1;
      // load once the window has run out
      if( (sw_sync == sw_last) && (stable_cnt == CNT_W'(DEB - 1)) )
        mode_o <= decode_switches(sw_sync);
    end

endmodule

`default_nettype wire

// ==== i2s_tx.sv ====
// i2s transmitter toward the dac
`timescale 1ns/100ps
`default_nettype none

`include "audio_macros.svh"

module i2s_tx
  import audio_pkg::*;
  import ctrl_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n_i,
  input  logic       lrclk_i,
  input  logic       bit_shift_stb_i,
  input  slot_cnt_t  slot_pos_i,
  input  chan_mode_e mode_i,
  input  logic       frame_valid_i,
  output logic       frame_ready_o,
  input  sample_t    left_i,
  input  sample_t    right_i,
  output logic       dac_data_o,
  output logic       underrun_o
);

localparam int W = `AUDIO_SAMPLE_W;

logic              left_start;
logic              data_pos;
logic              primed;
slot_cnt_t         bit_idx;
logic signed [W:0] mono_sum;
sample_t           proc_left;
sample_t           proc_right;
sample_t           hold_left;
sample_t           hold_right;
sample_t           cur_sample;

// falling edge that opens the left slot
assign left_start    = bit_shift_stb_i && !lrclk_i && (slot_pos_i == '0);
assign frame_ready_o = left_start && frame_valid_i;
assign data_pos      = (slot_pos_i != '0) && (slot_pos_i <= slot_cnt_t'(W));
// position 1 carries the msb
assign bit_idx       = slot_cnt_t'(W) - slot_pos_i;
assign cur_sample    = lrclk_i ? hold_right : hold_left;

// ************************************************************
// channel mode
// ************************************************************

// sign-extended sum, the shift drops the lsb
assign mono_sum = {left_i[W-1], left_i} + {right_i[W-1], right_i};

always_comb
  case( mode_i )
    MODE_SWAP:
      begin
        proc_left  = right_i;
        proc_right = left_i;
      end
    MODE_MONO:
      begin
        proc_left  = mono_sum[W:1];
        proc_right = mono_sum[W:1];
      end
    MODE_MUTE:
      begin
        proc_left  = '0;
        proc_right = '0;
      end
    default:
      begin
        proc_left  = left_i;
        proc_right = right_i;
      end
  endcase

// ************************************************************
// frame hold and serializer
// ************************************************************

always_ff @( posedge sys_clk or negedge rst_n_i )
  if( !rst_n_i )
    begin
      hold_left  <= '0;
      hold_right <= '0;
      primed     <= 1'b0;
      underrun_o <= 1'b0;
      dac_data_o <= 1'b0;
    end
  else
    begin
      if( left_start )
        begin
          if( frame_valid_i )
            begin
              hold_left  <= proc_left;
              hold_right <= proc_right;
              primed     <= 1'b1;
            end
          else
            begin
              // empty fifo, send silence
              hold_left  <= '0;
              hold_right <= '0;
              if( primed )
                underrun_o <= 1'b1;
            end
        end
      // pad bits 0 and 25..31 stay zero
      if( bit_shift_stb_i )
        dac_data_o <= data_pos ? cur_sample[bit_idx] : 1'b0;
    end

// a take only at a left start with data
a_take_at_left_start: assert property (
  @( posedge sys_clk ) disable iff ( !rst_n_i )
  frame_ready_o |-> (left_start && frame_valid_i)
);

endmodule

`default_nettype wire

// ==== audio_top.sv ====
// audio sample path top level
`timescale 1ns/100ps
`default_nettype none

module audio_top
  import audio_pkg::*;
  import ctrl_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n_i,
  input  logic [1:0] sw_i,
  input  logic       i2s_dout_i,
  output logic       i2s_bclk_o,
  output logic       i2s_lrclk_o,
  output logic       i2s_din_o,
  output logic       overrun_o,
  output logic       underrun_o
);

// clock generator fan-out
logic       bit_sample_stb;
logic       bit_shift_stb;
slot_cnt_t  slot_pos;

// receiver to fifo
logic       in_valid;
logic       in_ready;
sample_t    in_left;
sample_t    in_right;

// fifo to transmitter
logic       out_valid;
logic       out_ready;
sample_t    out_left;
sample_t    out_right;

chan_mode_e chan_mode;

// ************************************************************
// clocks
// ************************************************************

i2s_clk_gen i2s_clk_gen_inst (
  .sys_clk          ( sys_clk        ),
  .rst_n_i          ( rst_n_i        ),
  .bclk_o           ( i2s_bclk_o     ),
  .lrclk_o          ( i2s_lrclk_o    ),
  .bit_sample_stb_o ( bit_sample_stb ),
  .bit_shift_stb_o  ( bit_shift_stb  ),
  .slot_pos_o       ( slot_pos       )
);

// ************************************************************
// sample path
// ************************************************************

i2s_rx i2s_rx_inst (
  .sys_clk          ( sys_clk        ),
  .rst_n_i          ( rst_n_i        ),
  .adc_data_i       ( i2s_dout_i     ),
  .lrclk_i          ( i2s_lrclk_o    ),
  .bit_sample_stb_i ( bit_sample_stb ),
  .slot_pos_i       ( slot_pos       ),
  .frame_valid_o    ( in_valid       ),
  .frame_ready_i    ( in_ready       ),
  .left_o           ( in_left        ),
  .right_o          ( in_right       ),
  .overrun_o        ( overrun_o      )
);

frame_fifo frame_fifo_inst (
  .sys_clk          ( sys_clk        ),
  .rst_n_i          ( rst_n_i        ),
  .in_valid_i       ( in_valid       ),
  .in_ready_o       ( in_ready       ),
  .in_left_i        ( in_left        ),
  .in_right_i       ( in_right       ),
  .out_valid_o      ( out_valid      ),
  .out_ready_i      ( out_ready      ),
  .out_left_o       ( out_left       ),
  .out_right_o      ( out_right      )
);

// mode select from the board switches
switch_debouncer switch_debouncer_inst (
  .sys_clk          ( sys_clk        ),
  .rst_n_i          ( rst_n_i        ),
  .sw_i             ( sw_i           ),
  .mode_o           ( chan_mode      )
);

i2s_tx i2s_tx_inst (
  .sys_clk          ( sys_clk        ),
  .rst_n_i          ( rst_n_i        ),
  .lrclk_i          ( i2s_lrclk_o    ),
  .bit_shift_stb_i  ( bit_shift_stb  ),
  .slot_pos_i       ( slot_pos       ),
  .mode_i           ( chan_mode      ),
  .frame_valid_i    ( out_valid      ),
  .frame_ready_o    ( out_ready      ),
  .left_i           ( out_left       ),
  .right_i          ( out_right      ),
  .dac_data_o       ( i2s_din_o      ),
  .underrun_o       ( underrun_o     )
);

endmodule

`default_nettype wire

// ==== tb_audio_top.sv ====
// audio path testbench
`timescale 1ns/100ps
`default_nettype none

`include "audio_macros.svh"

module tb_audio_top
  import ctrl_pkg::*;
();

localparam int W             = `AUDIO_SAMPLE_W;
localparam int CLK_PERIOD    = 20;
localparam int FRAME_CYCLES  = 2 * `AUDIO_SLOT_W * 2 * `AUDIO_BCLK_HALF;
// zero frames allowed before the first real one
localparam int START_FRAMES  = 4;
localparam int PASS_FRAMES   = 12;
localparam int SETTLE_FRAMES = 3;
localparam int MODE_FRAMES   = 8;
localparam int TOTAL_FRAMES  = START_FRAMES + PASS_FRAMES + 3 * (SETTLE_FRAMES + MODE_FRAMES);
localparam int TIMEOUT_NS    = 2 * TOTAL_FRAMES * FRAME_CYCLES * CLK_PERIOD;

logic       sys_clk;
logic       rst_n_i;
logic [1:0] sw;
logic       i2s_dout;
logic       i2s_bclk;
logic       i2s_lrclk;
logic       i2s_din;
logic       overrun;
logic       underrun;

// {left, right} per frame
logic [2*W-1:0] sent_q [$];
logic [2*W-1:0] cap_q  [$];

int pass_cnt;
int fail_cnt;

audio_top audio_top_inst (
  .sys_clk     ( sys_clk   ),
  .rst_n_i     ( rst_n_i   ),
  .sw_i        ( sw        ),
  .i2s_dout_i  ( i2s_dout  ),
  .i2s_bclk_o  ( i2s_bclk  ),
  .i2s_lrclk_o ( i2s_lrclk ),
  .i2s_din_o   ( i2s_din   ),
  .overrun_o   ( overrun   ),
  .underrun_o  ( underrun  )
);

always #(CLK_PERIOD / 2) sys_clk = !sys_clk;

// ************************************************************
// reference model
// ************************************************************

function automatic logic [2*W-1:0] expected_pair(input logic [2*W-1:0] frame,
                                                 input chan_mode_e    mode);
  logic [W-1:0]   l;
  logic [W-1:0]   r;
  logic [2*W-1:0] res;
  int             sum;
  l = frame[2*W-1:W];
  r = frame[W-1:0];
  case (mode)
    MODE_SWAP:
      res = {r, l};
    MODE_MONO:
      begin
        // average, floor toward minus infinity
        sum = int'($signed(l)) + int'($signed(r));
        sum = sum >>> 1;
        res = {W'(sum), W'(sum)};
      end
    MODE_MUTE:
      res = '0;
    default:
      res = frame;
  endcase
  return res;
endfunction

function automatic logic [W-1:0] random_sample();
  logic [W-1:0] s;
  s = W'($urandom);
  // keep every sample non-zero
  if (s == '0)
    s = W'(1);
  return s;
endfunction

// ************************************************************
// adc model and dac capture
// ************************************************************

// bit clock edges seen at the falling sys_clk edge
initial
  begin : adc_model
    logic         prev_bclk;
    logic         prev_lr;
    int           pos;
    logic [W-1:0] cur_left;
    logic [W-1:0] cur_right;
    i2s_dout  = 1'b0;
    void'($urandom(32'hf2a6_c5f4));
    @(posedge rst_n_i);
    // reset leaves the generator at the top of a left slot
    cur_left  = random_sample();
    cur_right = random_sample();
    sent_q.push_back({cur_left, cur_right});
    prev_bclk = 1'b0;
    prev_lr   = 1'b0;
    pos       = 0;
    forever
      begin
        @(negedge sys_clk);
        if (prev_bclk && !i2s_bclk)
          begin
            if (i2s_lrclk != prev_lr)
              begin
                pos = 0;
                // new left slot, new frame
                if (!i2s_lrclk)
                  begin
                    cur_left  = random_sample();
                    cur_right = random_sample();
                    sent_q.push_back({cur_left, cur_right});
                  end
              end
            else
              pos = pos + 1;
            prev_lr = i2s_lrclk;
            // msb one bit clock after the word clock change
            if (pos >= 1 && pos <= W)
              i2s_dout = i2s_lrclk ? cur_right[W-pos] : cur_left[W-pos];
            else
              i2s_dout = 1'b0;
          end
        prev_bclk = i2s_bclk;
      end
  end

initial
  begin : dac_capture
    logic         prev_bclk;
    logic         prev_lr;
    int           pos;
    logic [W-1:0] shreg;
    logic [W-1:0] cap_left;
    @(posedge rst_n_i);
    prev_bclk = 1'b0;
    // forces a slot start on the first rising edge
    prev_lr   = 1'b1;
    pos       = 0;
    shreg     = '0;
    cap_left  = '0;
    forever
      begin
        @(negedge sys_clk);
        if (!prev_bclk && i2s_bclk)
          begin
            if (i2s_lrclk != prev_lr)
              begin
                pos   = 0;
                shreg = '0;
              end
            else
              pos = pos + 1;
            prev_lr = i2s_lrclk;
            if (pos >= 1 && pos <= W)
              shreg = {shreg[W-2:0], i2s_din};
            // last data bit of the slot
            if (pos == W)
              begin
                if (!i2s_lrclk)
                  cap_left = shreg;
                else
                  cap_q.push_back({cap_left, shreg});
              end
          end
        prev_bclk = i2s_bclk;
      end
  end

// ************************************************************
// checker helpers
// ************************************************************

task automatic next_dac(output logic [2*W-1:0] f);
  while (cap_q.size() == 0)
    @(negedge sys_clk);
  f = cap_q.pop_front();
endtask

task automatic next_adc(output logic [2*W-1:0] f);
  while (sent_q.size() == 0)
    @(negedge sys_clk);
  f = sent_q.pop_front();
endtask

task automatic compare_frame(input logic [2*W-1:0] exp, input logic [2*W-1:0] got);
  if (got[2*W-1:W] !== exp[2*W-1:W])
    begin
      $display("MISMATCH at %0t: i2s_din_o left expected %h actual %h",
               $time, exp[2*W-1:W], got[2*W-1:W]);
      fail_cnt++;
    end
  else
    pass_cnt++;
  if (got[W-1:0] !== exp[W-1:0])
    begin
      $display("MISMATCH at %0t: i2s_din_o right expected %h actual %h",
               $time, exp[W-1:0], got[W-1:0]);
      fail_cnt++;
    end
  else
    pass_cnt++;
endtask

task automatic check_low(input string name, input logic v);
  if (v !== 1'b0)
    begin
      $display("MISMATCH at %0t: %s expected 0 actual %b", $time, name, v);
      fail_cnt++;
    end
  else
    pass_cnt++;
endtask

task automatic report(input string name, input int fails_at_start);
  if (fail_cnt == fails_at_start)
    $display("%s: done, no errors", name);
  else
    $display("%s: done, %0d errors", name, fail_cnt - fails_at_start);
endtask

// switch change, settle window, then compare a run of frames
task automatic run_mode(input chan_mode_e mode);
  logic [2*W-1:0] got;
  logic [2*W-1:0] sent;
  @(negedge sys_clk);
  sw = mode;
  repeat (SETTLE_FRAMES)
    begin
      next_dac(got);
      next_adc(sent);
    end
  repeat (MODE_FRAMES)
    begin
      next_dac(got);
      next_adc(sent);
      compare_frame(expected_pair(sent, mode), got);
    end
endtask

// ************************************************************
// test sequence
// ************************************************************

initial
  begin : main_seq
    logic [2*W-1:0] got;
    logic [2*W-1:0] sent;
    int             errs;
    int             zero_frames;
    sys_clk  = 1'b0;
    rst_n_i  = 1'b0;
    sw       = 2'b00;
    pass_cnt = 0;
    fail_cnt = 0;
    repeat (5) @(negedge sys_clk);
    rst_n_i = 1'b1;

    // startup
    errs = fail_cnt;
    check_low("i2s_bclk_o", i2s_bclk);
    check_low("i2s_lrclk_o", i2s_lrclk);
    check_low("i2s_din_o", i2s_din);
    check_low("overrun_o", overrun);
    check_low("underrun_o", underrun);
    check_low("in_valid", audio_top_inst.in_valid);
    check_low("out_ready", audio_top_inst.out_ready);
    zero_frames = 0;
    next_dac(got);
    // unprimed transmitter sends silence without a flag
    while (got == '0 && zero_frames < START_FRAMES)
      begin
        zero_frames++;
        check_low("underrun_o", underrun);
        next_dac(got);
      end
    if (got == '0)
      begin
        $display("ERROR at %0t: no non-zero frame after %0d startup frames",
                 $time, zero_frames);
        fail_cnt++;
      end
    report("startup", errs);

    // pass mode, first real frame is the head of the queue
    errs = fail_cnt;
    next_adc(sent);
    compare_frame(expected_pair(sent, MODE_PASS), got);
    repeat (PASS_FRAMES - 1)
      begin
        next_dac(got);
        next_adc(sent);
        compare_frame(expected_pair(sent, MODE_PASS), got);
      end
    report("pass mode", errs);

    errs = fail_cnt;
    run_mode(MODE_SWAP);
    report("swap mode", errs);
    errs = fail_cnt;
    run_mode(MODE_MONO);
    report("mono mode", errs);
    errs = fail_cnt;
    run_mode(MODE_MUTE);
    report("mute mode", errs);

    // same frame rate on both sides, no loss
    errs = fail_cnt;
    check_low("overrun_o", overrun);
    check_low("underrun_o", underrun);
    report("flags", errs);

    $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

// run length bound
initial
  begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
audio_pkg.sv
ctrl_pkg.sv
i2s_clk_gen.sv
i2s_rx.sv
frame_fifo.sv
switch_debouncer.sv
i2s_tx.sv
audio_top.sv
tb_audio_top.sv

// ==== Makefile ====
# Verilator build for the audio sample path

VERILATOR ?= verilator
TOP       ?= tb_audio_top
SEED_ARGS ?= +verilator+seed+1
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f files.f

# the target fails unless the pass line appears
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
